// ==== design/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;             // One enable per byte

    typedef logic [ADDR_W-1:0] addr_t;              // Byte address
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [7:0]        led_t;               // LEDs and DIP switches

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    localparam addr_t BOOT_BASE = 32'h0001_0000;
    localparam addr_t BOOT_LEN  = 32'h0000_1000;
    localparam addr_t GPIO_BASE = 32'h4000_0000;
    localparam addr_t GPIO_LEN  = 32'h0000_1000;

    // Boot RAM holds 64-bit words
    localparam int BOOT_WORDS = BOOT_LEN / STRB_W;

    typedef logic [$clog2(BOOT_WORDS)-1:0] boot_idx_t;

    // GPIO slot comes from addr[5:3]
    typedef logic [2:0] gpio_sel_t;

    localparam gpio_sel_t GPIO_SEL_SWITCH_LED = 3'd0;

    // Pattern returned for unmapped or unused locations
    localparam data_t ERR_DATA = {32'h0000_0000, 32'hDEAD_BEEF};

    // ------------------------------------------------------------
    // Decode regions
    // ------------------------------------------------------------
    typedef enum logic [1:0]
    {
        REGION_NONE,
        REGION_BOOT,
        REGION_GPIO
    } region_e;

    // ------------------------------------------------------------
    // Request and response
    // ------------------------------------------------------------
    typedef struct packed
    {
        logic  we;      // 1 = write
        addr_t addr;
        strb_t be;
        data_t wdata;
    } bus_req_t;

    typedef struct packed
    {
        data_t rdata;
        logic  err;     // Set for unmapped addresses
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== design/periph_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_addr_decode
(
    input  wire                  clk_i,
    input  wire                  reset_i,
    input  logic                 req_valid_i,
    input  periph_pkg::bus_req_t req_i,
    output logic                 boot_req_valid_o,
    output logic                 gpio_req_valid_o,
    input  periph_pkg::data_t    boot_rdata_i,
    input  periph_pkg::data_t    gpio_rdata_i,
    output logic                 rsp_valid_o,
    output periph_pkg::bus_rsp_t rsp_o
);

    import periph_pkg::*;

    logic [ADDR_W-1:0] boot_off;        // Offset into each region
    logic [ADDR_W-1:0] gpio_off;
    region_e           region_d;
    region_e           region_q;
    logic              valid_q;
    logic              err_q;

    // ------------------------------------------------------------
    // Region match
    // ------------------------------------------------------------
    assign boot_off = req_i.addr - BOOT_BASE;
    assign gpio_off = req_i.addr - GPIO_BASE;

    always_comb
    begin
        if (boot_off < BOOT_LEN)
            region_d = REGION_BOOT;
        else if (gpio_off < GPIO_LEN)
            region_d = REGION_GPIO;
        else
            region_d = REGION_NONE;
    end

    // Single-cycle strobes, request payload goes straight through
    assign boot_req_valid_o = req_valid_i && (region_d == REGION_BOOT);
    assign gpio_req_valid_o = req_valid_i && (region_d == REGION_GPIO);

    // ------------------------------------------------------------
    // Response stage
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            valid_q  <= 1'b0;
            region_q <= REGION_NONE;
            err_q    <= 1'b0;
        end
        else
        begin
            valid_q <= req_valid_i;
            if (req_valid_i)
            begin
                region_q <= region_d;
                err_q    <= (region_d == REGION_NONE);
            end
        end
    end

    assign rsp_valid_o = valid_q;

    // Pick the data of whichever target was hit last cycle
    always_comb
    begin
        rsp_o.err = err_q;
        case (region_q)
            REGION_BOOT: rsp_o.rdata = boot_rdata_i;
            REGION_GPIO: rsp_o.rdata = gpio_rdata_i;
            default:     rsp_o.rdata = ERR_DATA;     // Unmapped
        endcase
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_one_target: assert property (@(posedge clk_i)
        !(boot_req_valid_o && gpio_req_valid_o))
        else $error("both target strobes high");

    // No stale response may leak out of reset
    a_rsp_after_reset: assert property (@(posedge clk_i)
        $past(reset_i) |-> !rsp_valid_o)
        else $error("response valid right after reset");

endmodule

`default_nettype wire

// ==== design/boot_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_ram
(
    input  wire                  clk_i,
    input  logic                 req_valid_i,
    input  periph_pkg::bus_req_t req_i,
    output periph_pkg::data_t    rdata_o
);

    import periph_pkg::*;

    data_t     mem [BOOT_WORDS];
    boot_idx_t idx;

    // Word index, byte offset dropped
    assign idx = req_i.addr[3 +: $bits(boot_idx_t)];

    // ------------------------------------------------------------
    // Write with byte enables
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (req_valid_i && req_i.we)
        begin
            for (int b = 0; b < STRB_W; b++)
            begin
                if (req_i.be[b])
                    mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------
    // Registered read
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (req_valid_i && !req_i.we)
            rdata_o <= mem[idx];   // Old word, one cycle latency
    end

    // Master should never issue a write that touches no byte
    a_write_has_be: assert property (@(posedge clk_i)
        (req_valid_i && req_i.we) |-> (req_i.be != '0))
        else $error("boot_ram write with empty byte enable");

endmodule

`default_nettype wire

// ==== design/gpio_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_regs
(
    input  wire                  clk_i,
    input  wire                  reset_i,
    input  logic                 req_valid_i,
    input  periph_pkg::bus_req_t req_i,
    input  periph_pkg::led_t     dip_switches_i,
    output periph_pkg::led_t     leds_o,
    output periph_pkg::data_t    rdata_o
);

    import periph_pkg::*;

    gpio_sel_t sel;
    gpio_sel_t sel_q;       // Slot of the last request
    logic      slot0_wr;
    logic      led_wr;
    led_t      led_q;

    // Register slot from addr[5:3]
    assign sel = req_i.addr[5:3];

    // ------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------
    assign slot0_wr = req_valid_i && req_i.we && (sel == GPIO_SEL_SWITCH_LED);

    // Only byte 0 of the word reaches the LEDs
    assign led_wr = slot0_wr && req_i.be[0];

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            led_q <= '0;    // LEDs dark after reset
        end
        else if (led_wr)
        begin
            led_q <= req_i.wdata[7:0];
        end
    end

    assign leds_o = led_q;

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (req_valid_i)
            sel_q <= sel;
    end

    // Switches are taken live in the response cycle
    always_comb
    begin
        if (sel_q == GPIO_SEL_SWITCH_LED)
            rdata_o = data_t'(dip_switches_i);
        else
            rdata_o = ERR_DATA;     // Unused slot
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // LEDs may only move after a slot 0 write
    a_leds_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        !slot0_wr |=> $stable(leds_o))
        else $error("leds_o changed without a slot 0 write");

endmodule

`default_nettype wire

// ==== design/periph_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem
(
    input  wire                  clk_i,
    input  wire                  reset_i,
    // Request port
    input  logic                 req_valid_i,
    input  periph_pkg::bus_req_t req_i,
    // Response port, one cycle after the request
    output logic                 rsp_valid_o,
    output periph_pkg::bus_rsp_t rsp_o,
    // Board IO
    input  periph_pkg::led_t     dip_switches_i,
    output periph_pkg::led_t     leds_o
);

    import periph_pkg::*;

    logic  boot_req_valid;
    logic  gpio_req_valid;
    data_t boot_rdata;
    data_t gpio_rdata;

    // ------------------------------------------------------------
    // Decoder
    // ------------------------------------------------------------
    periph_addr_decode u_decode
    (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .boot_req_valid_o (boot_req_valid),
        .gpio_req_valid_o (gpio_req_valid),
        .boot_rdata_i     (boot_rdata),
        .gpio_rdata_i     (gpio_rdata),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_o            (rsp_o)
    );

    // ------------------------------------------------------------
    // Boot memory
    // ------------------------------------------------------------
    boot_ram u_boot_ram
    (
        .clk_i       (clk_i),
        .req_valid_i (boot_req_valid),
        .req_i       (req_i),
        .rdata_o     (boot_rdata)
    );

    // ------------------------------------------------------------
    // GPIO
    // ------------------------------------------------------------
    gpio_regs u_gpio
    (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_valid_i    (gpio_req_valid),
        .req_i          (req_i),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o),
        .rdata_o        (gpio_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/periph_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_tb;

    import periph_pkg::*;

    // ------------------------------------------------------------
    // Run constants
    // ------------------------------------------------------------
    localparam int SEED       = 49;
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYC  = 8;
    localparam int N_PARTIAL  = 300;        // Write and read pairs
    localparam int N_GPIO     = 200;
    localparam int N_UNMAPPED = 100;
    localparam int N_RECHECK  = 16;
    localparam int N_MIX      = 600;
    localparam int N_REQ      = 2 * BOOT_WORDS + 2 * N_PARTIAL + N_GPIO + N_UNMAPPED
                                + N_RECHECK + N_MIX;

    typedef struct packed
    {
        bus_rsp_t rsp;
        logic     chk_data;     // rdata is don't care after writes
        logic     dip_read;     // rdata is the live switch value
    } exp_t;

    logic        clk_i;
    logic        reset_i;
    logic        req_valid_i;
    bus_req_t    req_i;
    logic        rsp_valid_o;
    bus_rsp_t    rsp_o;
    led_t        dip_switches_i;
    led_t        leds_o;

    data_t       boot_model [boot_idx_t];
    led_t        led_next;      // Updated when a write is issued
    led_t        led_exp;       // What leds_o shows in this cycle
    exp_t        exp_q [$];
    logic        req_pending;   // Request driven in the previous cycle
    logic        checking;
    int          rsp_errors;
    int          led_errors;
    int          proto_errors;

    periph_subsystem dut0
    (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_o          (rsp_o),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // Address and data helpers
    // ------------------------------------------------------------
    function automatic region_e region_of(input addr_t a);
        addr_t boot_off;
        addr_t gpio_off;
        boot_off = a - BOOT_BASE;
        gpio_off = a - GPIO_BASE;
        if (boot_off < BOOT_LEN)
            return REGION_BOOT;
        if (gpio_off < GPIO_LEN)
            return REGION_GPIO;
        return REGION_NONE;
    endfunction

    function automatic addr_t boot_addr(input boot_idx_t idx);
        return BOOT_BASE + addr_t'({idx, 3'b000});
    endfunction

    function automatic addr_t gpio_addr(input gpio_sel_t sel);
        logic [5:0] upper;
        upper = 6'($urandom);   // Slots repeat every 64 bytes
        return GPIO_BASE + addr_t'({upper, sel, 3'b000});
    endfunction

    function automatic gpio_sel_t pick_sel();
        if (($urandom % 2) == 0)
            return GPIO_SEL_SWITCH_LED;
        return gpio_sel_t'($urandom);
    endfunction

    function automatic addr_t unmapped_addr();
        addr_t a;
        case ($urandom % 5)
            0: a = BOOT_BASE - 8;           // Just outside each region
            1: a = BOOT_BASE + BOOT_LEN;
            2: a = GPIO_BASE - 8;
            3: a = GPIO_BASE + GPIO_LEN;
            default:
            begin
                a = $urandom;
                while (region_of(a) != REGION_NONE)
                    a = $urandom;
            end
        endcase
        return a;
    endfunction

    function automatic data_t rand_data();
        return {$urandom, $urandom};
    endfunction

    function automatic strb_t rand_be();
        strb_t be;
        be = strb_t'($urandom);
        while (be == '0)
            be = strb_t'($urandom);
        return be;
    endfunction

    // ------------------------------------------------------------
    // Drive one request and queue its expected response
    // ------------------------------------------------------------
    task automatic issue(input logic we, input addr_t addr, input strb_t be, input data_t wdata);
        bus_req_t  r;
        exp_t      e;
        boot_idx_t idx;
        data_t     word;
        int        b;
        @(posedge clk_i);
        #1;
        r.we        = we;
        r.addr      = addr;
        r.be        = be;
        r.wdata     = wdata;
        e.rsp.rdata = ERR_DATA;
        e.rsp.err   = 1'b0;
        e.chk_data  = 1'b1;
        e.dip_read  = 1'b0;
        case (region_of(addr))
            REGION_BOOT:
            begin
                idx = addr[11:3];
                if (we)
                begin
                    word = boot_model.exists(idx) ? boot_model[idx] : '0;
                    for (b = 0; b < STRB_W; b++)
                    begin
                        if (be[b])
                            word[b*8 +: 8] = wdata[b*8 +: 8];
                    end
                    boot_model[idx] = word;
                    e.chk_data = 1'b0;
                end
                else
                begin
                    e.rsp.rdata = boot_model[idx];
                end
            end
            REGION_GPIO:
            begin
                if (we)
                begin
                    if (addr[5:3] == GPIO_SEL_SWITCH_LED && be[0])
                        led_next = wdata[7:0];
                    e.chk_data = 1'b0;
                end
                else if (addr[5:3] == GPIO_SEL_SWITCH_LED)
                begin
                    e.dip_read = 1'b1;
                end
            end
            default:
                e.rsp.err = 1'b1;   // ERR_DATA already set
        endcase
        req_valid_i = 1'b1;
        req_i       = r;
        exp_q.push_back(e);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk_i);
            #1;
            req_valid_i = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input logic chk_data);
        if (got.err !== exp.err)
        begin
            $display("Fail rsp_o.err got %h exp %h at %0t", got.err, exp.err, $time);
            rsp_errors++;
        end
        if (chk_data && got.rdata !== exp.rdata)
        begin
            $display("Fail rsp_o.rdata got %h exp %h at %0t", got.rdata, exp.rdata, $time);
            rsp_errors++;
        end
    endtask

    task automatic check_led(input led_t got, input led_t exp);
        if (got !== exp)
        begin
            $display("Fail leds_o got %h exp %h at %0t", got, exp, $time);
            led_errors++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_i)
    begin : monitor
        exp_t     e;
        bus_rsp_t want;
        if (checking)
        begin
            check_led(leds_o, led_exp);
            led_exp = led_next;
            if (rsp_valid_o !== req_pending)
            begin
                if (req_pending)
                    $display("No response one cycle after a request at %0t", $time);
                else
                    $display("Response valid without a request at %0t", $time);
                proto_errors++;
            end
            if (rsp_valid_o === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Response arrived with nothing outstanding at %0t", $time);
                    proto_errors++;
                end
                else
                begin
                    e    = exp_q.pop_front();
                    want = e.rsp;
                    if (e.dip_read)
                        want.rdata = data_t'(dip_switches_i);
                    check_rsp(rsp_o, want, e.chk_data);
                end
            end
            else if (req_pending && exp_q.size() > 0)
            begin
                e = exp_q.pop_front();  // Keep the queue in step
            end
            req_pending = req_valid_i;
        end
    end

    initial
    begin
        #((N_REQ + 100) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin : main
        int kind;
        void'($urandom(SEED));
        reset_i        = 1'b1;
        req_valid_i    = 1'b0;
        req_i          = '0;
        dip_switches_i = '0;
        led_next       = '0;
        led_exp        = '0;
        req_pending    = 1'b0;
        checking       = 1'b0;
        rsp_errors     = 0;
        led_errors     = 0;
        proto_errors   = 0;
        repeat (RESET_CYC) @(posedge clk_i);
        #1;
        reset_i  = 1'b0;
        checking = 1'b1;

        // Quiet outputs right after reset
        @(negedge clk_i);
        if (rsp_valid_o !== 1'b0)
        begin
            $display("rsp_valid_o high after reset");
            proto_errors++;
        end
        check_led(leds_o, '0);

        // Fill the boot RAM, then read it all back
        for (int i = 0; i < BOOT_WORDS; i++)
            issue(1'b1, boot_addr(boot_idx_t'(i)), '1, rand_data());
        for (int i = 0; i < BOOT_WORDS; i++)
            issue(1'b0, boot_addr(boot_idx_t'(i)), '0, '0);
        idle(2);

        for (int i = 0; i < N_PARTIAL; i++)
        begin
            kind = $urandom;
            issue(1'b1, boot_addr(boot_idx_t'(kind)), rand_be(), rand_data());
            issue(1'b0, boot_addr(boot_idx_t'(kind)), '0, '0);
        end
        idle(2);

        // GPIO with moving switches
        for (int i = 0; i < N_GPIO; i++)
        begin
            if (($urandom % 4) == 0)
                dip_switches_i = led_t'($urandom);
            issue(($urandom % 2) == 1, gpio_addr(pick_sel()), strb_t'($urandom), rand_data());
        end
        idle(2);

        for (int i = 0; i < N_UNMAPPED; i++)
            issue(($urandom % 2) == 1, unmapped_addr(), strb_t'($urandom), rand_data());
        for (int i = 0; i < N_RECHECK; i++)
            issue(1'b0, boot_addr(boot_idx_t'($urandom)), '0, '0);
        idle(2);

        // Back to back, every region
        for (int i = 0; i < N_MIX; i++)
        begin
            kind = $urandom % 6;
            if (($urandom % 8) == 0)
                dip_switches_i = led_t'($urandom);
            case (kind)
                0: issue(1'b1, boot_addr(boot_idx_t'($urandom)), rand_be(), rand_data());
                1: issue(1'b0, boot_addr(boot_idx_t'($urandom)), '0, '0);
                2: issue(1'b1, gpio_addr(pick_sel()), strb_t'($urandom), rand_data());
                3: issue(1'b0, gpio_addr(pick_sel()), '0, '0);
                default:
                    issue(($urandom % 2) == 1, unmapped_addr(), strb_t'($urandom), rand_data());
            endcase
        end
        idle(3);

        if (exp_q.size() != 0)
        begin
            $display("%0d responses never arrived", exp_q.size());
            proto_errors++;
        end
        $display("Errors: response %0d, led %0d, protocol %0d",
                 rsp_errors, led_errors, proto_errors);
        if (rsp_errors + led_errors + proto_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/periph_pkg.sv
design/periph_addr_decode.sv
design/boot_ram.sv
design/gpio_regs.sv
design/periph_subsystem.sv
dv/periph_tb.sv
